// File: dv/core_input.txt
// Program words from address 0, then expected x0..x15 at 0x20
// At 0x30: store address, stored word, retire count, program length
@00
123450B7 FFB00113 67808193 00001217  // lui addi addi auipc
402182B3 40115313 003123B3 0021C433  // sub srai slt xor
20802023 20002483 00118013 00848463  // sw lw addi-x0 beq
11100313 00109463 00C005EF 11100313  // skip bne jal skip
11100313 00014463 11100313 00317463  // skip blt skip bgeu
11100313 06000693 00468767 11100313  // skip addi jalr skip
11100313 00E5E7B3 00439513 0FF1F613  // skip or slli andi
00100073                             // ebreak
@20
00000000 12345000 FFFFFFFB 12345678
0000100C 1234567D FFFFFFFD 00000001
EDCBA983 EDCBA983 00000010 0000003C
00000078 00000060 0000005C 0000007C
@30
00000200 EDCBA983 00000016 0000001D

// File: dv/core_properties.sv
`timescale 1ns/100ps

module core_properties (
  input logic clk,
  input logic rst,
  input logic mem_valid_i,
  input logic mem_ready_i,
  input core_pkg::mem_req_t mem_req_i,
  input logic retire_valid_i,
  input core_pkg::retire_t retire_i,
  input logic halt_i
);

  // Request held until the handshake
  req_held: assert property (@(posedge clk) disable iff (rst)
    (mem_valid_i && !mem_ready_i) |=> (mem_valid_i && $stable(mem_req_i)))
    else $error("memory request changed or dropped before ready");

  no_retire_halted: assert property (@(posedge clk) disable iff (rst)
    halt_i |-> !retire_valid_i)
    else $error("retire seen while halted");

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    retire_valid_i |-> !(retire_i.we && retire_i.rd == '0))
    else $error("retire with write enable for x0");

endmodule

// File: dv/core_tb.sv
`timescale 1ns/100ps

bind core_top core_properties core_properties_i (
  .clk(clk),
  .rst(rst),
  .mem_valid_i(mem_valid_o),
  .mem_ready_i(mem_ready_i),
  .mem_req_i(mem_req_o),
  .retire_valid_i(retire_valid_o),
  .retire_i(retire_o),
  .halt_i(halt_o)
);

module core_tb;

  localparam int mem_words = 256;
  localparam int max_wait = 3;
  localparam int idle_cycles = 20;

  logic clk = 1'b0;
  logic rst;
  logic mem_valid;
  core_pkg::mem_req_t mem_req;
  logic mem_ready;
  core_pkg::word_t mem_rdata;
  logic retire_valid;
  core_pkg::retire_t retire;
  logic halt;

  // Program from 0x00, x0..x15 from 0x20, results from 0x30
  core_pkg::word_t input_words [64];
  core_pkg::word_t mem [mem_words];
  core_pkg::word_t trace_regs [16];
  core_pkg::mem_req_t held_req;
  core_pkg::word_t fetch_addr;
  int seed;
  int wait_left;
  int n_words;
  int limit;
  int retires;
  int checks;
  int errors;
  logic waiting;
  logic expect_fetch;

  always #2 clk = ~clk;

  core_top core_top_i (
    .clk(clk),
    .rst(rst),
    .mem_valid_o(mem_valid),
    .mem_req_o(mem_req),
    .mem_ready_i(mem_ready),
    .mem_rdata_i(mem_rdata),
    .retire_valid_o(retire_valid),
    .retire_o(retire),
    .halt_o(halt)
  );

  task automatic compare_value(input string name, input core_pkg::word_t got,
                               input core_pkg::word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic flag_failure(input string what);
    errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // Memory model with a random number of wait cycles per transfer
  always @(negedge clk)
  begin
    if (rst)
    begin
      mem_ready = 1'b0;
      waiting = 1'b0;
    end
    else if (mem_ready)
    begin
      mem_ready = 1'b0;
      waiting = 1'b0;
      wait_left = $unsigned($random(seed)) % (max_wait + 1);
    end
    else if (mem_valid || waiting)
    begin
      if (!waiting)
      begin
        held_req = mem_req;
        waiting = 1'b1;
        if (expect_fetch)
        begin
          if (retires == 0)
            compare_value("mem_req_o.addr", mem_req.addr, core_pkg::reset_pc);
          fetch_addr = mem_req.addr;
          expect_fetch = 1'b0;
        end
      end
      else
      begin
        compare_value("mem_valid_o", {31'b0, mem_valid}, 32'h1);
        compare_value("mem_req_o.addr", mem_req.addr, held_req.addr);
        compare_value("mem_req_o.we", {31'b0, mem_req.we}, {31'b0, held_req.we});
      end
      if (wait_left == 0)
      begin
        if (held_req.we)
        begin
          compare_value("mem_req_o.wstrb", {28'b0, held_req.wstrb}, 32'hf);
          mem[held_req.addr[9:2]] = held_req.wdata;
        end
        mem_rdata = mem[held_req.addr[9:2]];
        mem_ready = 1'b1;
      end
      else
      begin
        wait_left--;
      end
    end
  end

  // Retire trace monitor
  always @(negedge clk)
  begin
    if (!rst && retire_valid)
    begin
      retires++;
      compare_value("retire_o.pc", retire.pc, fetch_addr);
      if (retire.we && retire.rd == '0)
        flag_failure("retire shows a register write to x0");
      if (retire.we)
        trace_regs[retire.rd] = retire.wdata;
      if (halt)
        flag_failure("retire while the core is halted");
      expect_fetch = 1'b1;
    end
  end

  initial
  begin
    seed = 32'hf7e1286c;
    rst = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    retires = 0;
    checks = 0;
    errors = 0;
    waiting = 1'b0;
    expect_fetch = 1'b1;
    fetch_addr = '0;
    for (int i = 0; i < 16; i++)
      trace_regs[i[3:0]] = '0;
    $readmemh("dv/core_input.txt", input_words);
    n_words = int'(input_words[51]);
    for (int i = 0; i < mem_words; i++)
      mem[i[7:0]] = {24'hbad0f0, i[7:0]};
    for (int i = 0; i < n_words; i++)
      mem[i[7:0]] = input_words[i[5:0]];
    wait_left = $unsigned($random(seed)) % (max_wait + 1);
    limit = 20 * n_words * max_wait;

    fork
      begin
        repeat (limit) @(posedge clk);
        errors++;
        $display("Timeout: core did not halt within %0d cycles", limit);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("test failed");
        $finish;
      end
    join_none

    repeat (2) @(posedge clk);
    @(negedge clk);
    compare_value("mem_valid_o", {31'b0, mem_valid}, 32'h0);
    compare_value("retire_valid_o", {31'b0, retire_valid}, 32'h0);
    compare_value("halt_o", {31'b0, halt}, 32'h0);
    rst = 1'b0;

    while (!halt)
      @(negedge clk);

    // Halted core stays quiet
    repeat (idle_cycles)
    begin
      @(negedge clk);
      compare_value("mem_valid_o", {31'b0, mem_valid}, 32'h0);
      compare_value("retire_valid_o", {31'b0, retire_valid}, 32'h0);
      compare_value("halt_o", {31'b0, halt}, 32'h1);
    end

    for (int r = 0; r < 16; r++)
    begin
      compare_value($sformatf("x%0d", r), core_top_i.core_regfile_i.regs[r[3:0]],
                    input_words[6'(32 + r)]);
      compare_value($sformatf("retire_o.wdata x%0d", r), trace_regs[r[3:0]],
                    input_words[6'(32 + r)]);
    end
    compare_value("stored memory word", mem[input_words[48][9:2]], input_words[49]);
    compare_value("retire count", retires, input_words[50]);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: files.f
src/core_pkg.sv
src/core_ctrl.sv
src/core_regfile.sv
src/core_decoder.sv
src/core_alu.sv
src/core_mem_port.sv
src/core_top.sv
dv/core_properties.sv
dv/core_tb.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f files.f --top-module core_tb -o core_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/core_tb_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$log"; then
  exit 1
fi
exit 0

// File: src/core_alu.sv
`timescale 1ns/100ps

module core_alu (
  input  core_pkg::decoded_t dec_i,
  input  core_pkg::word_t pc_i,
  input  core_pkg::word_t rs1_val_i,
  input  core_pkg::word_t rs2_val_i,
  output core_pkg::word_t result_o,
  output logic taken_o,
  output core_pkg::word_t next_pc_o
);

  core_pkg::word_t op_a;
  core_pkg::word_t op_b;
  core_pkg::word_t alu_res;
  core_pkg::word_t pc_plus4;
  logic use_imm;
  logic is_jump;
  logic br_cond;

  assign use_imm = (dec_i.cls == core_pkg::cls_op_imm) || (dec_i.cls == core_pkg::cls_load) ||
                   (dec_i.cls == core_pkg::cls_store) || (dec_i.cls == core_pkg::cls_lui) ||
                   (dec_i.cls == core_pkg::cls_auipc) || (dec_i.cls == core_pkg::cls_jalr);
  assign op_a = (dec_i.cls == core_pkg::cls_auipc) ? pc_i : rs1_val_i;
  assign op_b = use_imm ? dec_i.imm : rs2_val_i;

  always_comb
  begin
    case (dec_i.alu_op)
      core_pkg::alu_sub:  alu_res = op_a - op_b;
      core_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
      core_pkg::alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      core_pkg::alu_sltu: alu_res = {31'b0, op_a < op_b};
      core_pkg::alu_xor:  alu_res = op_a ^ op_b;
      core_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
      core_pkg::alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
      core_pkg::alu_or:   alu_res = op_a | op_b;
      core_pkg::alu_and:  alu_res = op_a & op_b;
      core_pkg::alu_pass_b: alu_res = op_b;
      default:            alu_res = op_a + op_b;
    endcase
  end

  always_comb
  begin
    case (dec_i.funct3)
      3'b000:  br_cond = (rs1_val_i == rs2_val_i);
      3'b001:  br_cond = (rs1_val_i != rs2_val_i);
      3'b100:  br_cond = $signed(rs1_val_i) < $signed(rs2_val_i);
      3'b101:  br_cond = $signed(rs1_val_i) >= $signed(rs2_val_i);
      3'b110:  br_cond = rs1_val_i < rs2_val_i;
      3'b111:  br_cond = rs1_val_i >= rs2_val_i;
      default: br_cond = 1'b0;
    endcase
  end

  assign pc_plus4 = pc_i + 32'd4;
  assign is_jump = (dec_i.cls == core_pkg::cls_jal) || (dec_i.cls == core_pkg::cls_jalr);
  // High for every control transfer, jumps included
  assign taken_o = is_jump || ((dec_i.cls == core_pkg::cls_branch) && br_cond);

  assign result_o = is_jump ? pc_plus4 : alu_res;

  always_comb
  begin
    if (dec_i.cls == core_pkg::cls_jalr)
      next_pc_o = {alu_res[31:1], 1'b0};
    else if (taken_o)
      next_pc_o = pc_i + dec_i.imm;
    else
      next_pc_o = pc_plus4;
  end

endmodule

// File: src/core_ctrl.sv
`timescale 1ns/100ps

module core_ctrl (
  input  logic clk,
  input  logic rst,
  input  core_pkg::instr_class_e cls_i,
  input  logic taken_i,
  input  logic mem_done_i,
  output logic fetch_req_o,
  output logic ls_req_o,
  output logic ir_load_o,
  output logic rf_we_o,
  output logic pc_we_o,
  output logic retire_valid_o,
  output logic halt_o
);

  core_pkg::ctrl_state_e state_q;
  core_pkg::ctrl_state_e state_d;
  logic writes_rd;
  logic is_mem;
  logic in_wb;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= core_pkg::st_fetch;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign is_mem = (cls_i == core_pkg::cls_load) || (cls_i == core_pkg::cls_store);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      core_pkg::st_fetch:
      begin
        if (mem_done_i)
          state_d = core_pkg::st_decode;
      end
      core_pkg::st_decode:
        state_d = core_pkg::st_execute;
      core_pkg::st_execute:
        state_d = is_mem ? core_pkg::st_memory : core_pkg::st_writeback;
      core_pkg::st_memory:
      begin
        if (mem_done_i)
          state_d = core_pkg::st_writeback;
      end
      core_pkg::st_writeback:
        state_d = (cls_i == core_pkg::cls_ebreak) ? core_pkg::st_halted : core_pkg::st_fetch;
      default:
        state_d = core_pkg::st_halted;
    endcase
  end

  // Classes with a destination register
  assign writes_rd = (cls_i == core_pkg::cls_lui) || (cls_i == core_pkg::cls_auipc) ||
                     (cls_i == core_pkg::cls_jal) || (cls_i == core_pkg::cls_jalr) ||
                     (cls_i == core_pkg::cls_load) || (cls_i == core_pkg::cls_op_imm) ||
                     (cls_i == core_pkg::cls_op);

  assign in_wb = (state_q == core_pkg::st_writeback);

  // No fetch request while in reset
  assign fetch_req_o = !rst && (state_q == core_pkg::st_fetch);
  assign ls_req_o = (state_q == core_pkg::st_memory);
  assign ir_load_o = fetch_req_o && mem_done_i;
  assign rf_we_o = in_wb && writes_rd;
  // EBREAK leaves the PC on itself, redirects and sequential steps load next_pc
  assign pc_we_o = in_wb && (taken_i || (cls_i != core_pkg::cls_ebreak));
  assign retire_valid_o = in_wb;
  assign halt_o = (state_q == core_pkg::st_halted);

endmodule

// File: src/core_decoder.sv
`timescale 1ns/100ps

module core_decoder (
  input  core_pkg::word_t instr_i,
  output core_pkg::decoded_t dec_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic hi_rd;
  logic hi_rs1;
  logic hi_rs2;
  logic f7_zero;
  logic f7_alt;
  core_pkg::word_t imm_i;
  core_pkg::word_t imm_s;
  core_pkg::word_t imm_b;
  core_pkg::word_t imm_u;
  core_pkg::word_t imm_j;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  // RV32E has no x16 to x31
  assign hi_rd = instr_i[11];
  assign hi_rs1 = instr_i[19];
  assign hi_rs2 = instr_i[24];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt = (funct7 == 7'b0100000);

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'h000};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  function automatic core_pkg::alu_op_e alu_fn(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: alu_fn = alt ? core_pkg::alu_sub : core_pkg::alu_add;
      3'b001: alu_fn = core_pkg::alu_sll;
      3'b010: alu_fn = core_pkg::alu_slt;
      3'b011: alu_fn = core_pkg::alu_sltu;
      3'b100: alu_fn = core_pkg::alu_xor;
      3'b101: alu_fn = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
      3'b110: alu_fn = core_pkg::alu_or;
      default: alu_fn = core_pkg::alu_and;
    endcase
  endfunction

  always_comb
  begin
    dec_o.rs1 = instr_i[18:15];
    dec_o.rs2 = instr_i[23:20];
    dec_o.rd = instr_i[10:7];
    dec_o.funct3 = funct3;
    dec_o.imm = imm_i;
    dec_o.alu_op = core_pkg::alu_add;
    dec_o.cls = core_pkg::cls_illegal;
    case (opcode)
      core_pkg::op_lui:
      begin
        dec_o.imm = imm_u;
        dec_o.alu_op = core_pkg::alu_pass_b;
        if (!hi_rd)
          dec_o.cls = core_pkg::cls_lui;
      end
      core_pkg::op_auipc:
      begin
        dec_o.imm = imm_u;
        if (!hi_rd)
          dec_o.cls = core_pkg::cls_auipc;
      end
      core_pkg::op_jal:
      begin
        dec_o.imm = imm_j;
        if (!hi_rd)
          dec_o.cls = core_pkg::cls_jal;
      end
      core_pkg::op_jalr:
      begin
        if (funct3 == 3'b000 && !hi_rd && !hi_rs1)
          dec_o.cls = core_pkg::cls_jalr;
      end
      core_pkg::op_branch:
      begin
        dec_o.imm = imm_b;
        if (funct3[2:1] != 2'b01 && !hi_rs1 && !hi_rs2)
          dec_o.cls = core_pkg::cls_branch;
      end
      core_pkg::op_load:
      begin
        if (funct3 == 3'b010 && !hi_rd && !hi_rs1)
          dec_o.cls = core_pkg::cls_load;
      end
      core_pkg::op_store:
      begin
        dec_o.imm = imm_s;
        if (funct3 == 3'b010 && !hi_rs1 && !hi_rs2)
          dec_o.cls = core_pkg::cls_store;
      end
      core_pkg::op_imm:
      begin
        // Only shifts carry a funct7, and only SRAI may set bit 30
        dec_o.alu_op = alu_fn(funct3, funct3 == 3'b101 && instr_i[30]);
        if (!hi_rd && !hi_rs1 && (funct3[1:0] != 2'b01 || f7_zero ||
            (funct3 == 3'b101 && f7_alt)))
          dec_o.cls = core_pkg::cls_op_imm;
      end
      core_pkg::op_op:
      begin
        dec_o.alu_op = alu_fn(funct3, instr_i[30]);
        if (!hi_rd && !hi_rs1 && !hi_rs2 && (f7_zero ||
            (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))))
          dec_o.cls = core_pkg::cls_op;
      end
      core_pkg::op_system:
      begin
        if (instr_i == core_pkg::ebreak_word)
          dec_o.cls = core_pkg::cls_ebreak;
      end
      default:
        dec_o.cls = core_pkg::cls_illegal;
    endcase
  end

endmodule

// File: src/core_mem_port.sv
`timescale 1ns/100ps

module core_mem_port (
  input  logic clk,
  input  logic rst,
  input  logic fetch_req_i,
  input  logic ls_req_i,
  input  core_pkg::word_t pc_i,
  input  core_pkg::word_t ls_addr_i,
  input  core_pkg::word_t store_data_i,
  input  logic is_store_i,
  input  logic ir_load_i,
  output core_pkg::word_t instr_o,
  output core_pkg::word_t load_data_o,
  output logic mem_done_o,
  output logic mem_valid_o,
  output core_pkg::mem_req_t mem_req_o,
  input  logic mem_ready_i,
  input  core_pkg::word_t mem_rdata_i
);

  logic store_req;

  assign store_req = ls_req_i && is_store_i;

  assign mem_valid_o = fetch_req_i || ls_req_i;
  // Word access only, low address bits dropped
  assign mem_req_o.addr = ls_req_i ? {ls_addr_i[31:2], 2'b00} : pc_i;
  assign mem_req_o.wdata = store_data_i;
  assign mem_req_o.wstrb = {4{store_req}};
  assign mem_req_o.we = store_req;

  assign mem_done_o = mem_valid_o && mem_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      instr_o <= '0;
    end
    else if (ir_load_i)
    begin
      instr_o <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ls_req_i && !is_store_i && mem_done_o)
    begin
      load_data_o <= mem_rdata_i;
    end
  end

endmodule

// File: src/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0] reg_idx_t;

  localparam word_t reset_pc = 32'h0000_0000;
  localparam word_t ebreak_word = 32'h0010_0073;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_op     = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [3:0] {
    cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load,
    cls_store, cls_op_imm, cls_op, cls_ebreak, cls_illegal
  } instr_class_e;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halted
  } ctrl_state_e;

  typedef struct packed {
    instr_class_e cls;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t imm;
    alu_op_e alu_op;
    logic [2:0] funct3;
  } decoded_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic [3:0] wstrb;
    logic we;
  } mem_req_t;

  typedef struct packed {
    word_t pc;
    reg_idx_t rd;
    word_t wdata;
    logic we;
  } retire_t;

endpackage

// File: src/core_regfile.sv
`timescale 1ns/100ps

module core_regfile (
  input  logic clk,
  input  logic rst,
  input  logic we_i,
  input  core_pkg::reg_idx_t waddr_i,
  input  core_pkg::word_t wdata_i,
  input  core_pkg::reg_idx_t raddr1_i,
  input  core_pkg::reg_idx_t raddr2_i,
  output core_pkg::word_t rdata1_o,
  output core_pkg::word_t rdata2_o
);

  core_pkg::word_t regs [16];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is never written, so it reads zero
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

// File: src/core_top.sv
`timescale 1ns/100ps

module core_top (
  input  logic clk,
  input  logic rst,
  output logic mem_valid_o,
  output core_pkg::mem_req_t mem_req_o,
  input  logic mem_ready_i,
  input  core_pkg::word_t mem_rdata_i,
  output logic retire_valid_o,
  output core_pkg::retire_t retire_o,
  output logic halt_o
);

  core_pkg::word_t pc_q;
  core_pkg::word_t instr;
  core_pkg::word_t load_data;
  core_pkg::word_t rs1_val;
  core_pkg::word_t rs2_val;
  core_pkg::word_t alu_result;
  core_pkg::word_t next_pc;
  core_pkg::word_t wb_data;
  core_pkg::decoded_t dec;
  logic taken;
  logic mem_done;
  logic fetch_req;
  logic ls_req;
  logic ir_load;
  logic rf_we;
  logic pc_we;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= core_pkg::reset_pc;
    end
    else if (pc_we)
    begin
      pc_q <= next_pc;
    end
  end

  assign wb_data = (dec.cls == core_pkg::cls_load) ? load_data : alu_result;

  core_ctrl core_ctrl_i (
    .clk(clk), .rst(rst),
    .cls_i(dec.cls), .taken_i(taken), .mem_done_i(mem_done),
    .fetch_req_o(fetch_req), .ls_req_o(ls_req), .ir_load_o(ir_load),
    .rf_we_o(rf_we), .pc_we_o(pc_we),
    .retire_valid_o(retire_valid_o), .halt_o(halt_o)
  );

  core_mem_port core_mem_port_i (
    .clk(clk), .rst(rst),
    .fetch_req_i(fetch_req), .ls_req_i(ls_req),
    .pc_i(pc_q), .ls_addr_i(alu_result), .store_data_i(rs2_val),
    .is_store_i(dec.cls == core_pkg::cls_store), .ir_load_i(ir_load),
    .instr_o(instr), .load_data_o(load_data), .mem_done_o(mem_done),
    .mem_valid_o(mem_valid_o), .mem_req_o(mem_req_o),
    .mem_ready_i(mem_ready_i), .mem_rdata_i(mem_rdata_i)
  );

  core_decoder core_decoder_i (
    .instr_i(instr),
    .dec_o(dec)
  );

  core_regfile core_regfile_i (
    .clk(clk), .rst(rst),
    .we_i(rf_we), .waddr_i(dec.rd), .wdata_i(wb_data),
    .raddr1_i(dec.rs1), .raddr2_i(dec.rs2),
    .rdata1_o(rs1_val), .rdata2_o(rs2_val)
  );

  core_alu core_alu_i (
    .dec_i(dec), .pc_i(pc_q),
    .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
    .result_o(alu_result), .taken_o(taken), .next_pc_o(next_pc)
  );

  // Trace of the instruction retiring in write-back
  assign retire_o.pc = pc_q;
  assign retire_o.rd = dec.rd;
  assign retire_o.wdata = wb_data;
  assign retire_o.we = rf_we && (dec.rd != '0);

endmodule
